/* build.f */
+incdir+include
hdl/la_csr_pkg.sv
hdl/la_excp_pkg.sv
hdl/csr_timer.sv
hdl/csr_regs.sv
hdl/csr_top.sv
tests/csr_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module csr_tb -Mdir obj_dir -f build.f

sim_out=$(./obj_dir/Vcsr_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^sim passed$"; then
    exit 0
fi
exit 1

/* include/csr_tb_cases.svh */
// columns: name, action, register, mask, value, expected read value, random mask and value
// commit rows carry the cause code in the register column, pc in mask, bad address in value

typedef enum int {
    ACT_WRITE,
    ACT_CHECK,
    ACT_CHECK_MODEL,
    ACT_COMMIT,
    ACT_RETURN,
    ACT_HWINT,
    ACT_CHECK_INT,
    ACT_CHECK_PORTS,
    ACT_WAIT_TIMER,
    ACT_COUNT
} action_t;

typedef struct {
    string    name;
    action_t  act;
    csr_num_t num;
    word_t    mask;
    word_t    value;
    word_t    expected;
    bit       rnd;
} step_t;

step_t steps[$];

task automatic add_step(string name, action_t act, csr_num_t num, word_t mask,
                        word_t value, word_t expected, bit rnd);
    step_t st;
    st.name     = name;
    st.act      = act;
    st.num      = num;
    st.mask     = mask;
    st.value    = value;
    st.expected = expected;
    st.rnd      = rnd;
    steps.push_back(st);
endtask

task automatic load_cases();
    // state after reset
    add_step("reset crmd",    ACT_CHECK,       CSR_CRMD,  '0, '0, 32'h0000_0008, 1'b0);
    add_step("reset tid",     ACT_CHECK,       CSR_TID,   '0, '0, RESET_TID, 1'b0);
    add_step("reset has_int", ACT_CHECK_INT,   CSR_CRMD,  '0, '0, '0, 1'b0);
    add_step("reset estat",   ACT_CHECK_MODEL, CSR_ESTAT, '0, '0, '0, 1'b0);
    // masked writes
    add_step("save0 fill",  ACT_WRITE,       CSR_SAVE0, 32'hFFFF_FFFF, 32'hA5A5_5A5A, '0, 1'b0);
    add_step("save0 merge", ACT_WRITE,       CSR_SAVE0, '0, '0, '0, 1'b1);
    add_step("save0 read",  ACT_CHECK_MODEL, CSR_SAVE0, '0, '0, '0, 1'b0);
    add_step("save1 merge", ACT_WRITE,       CSR_SAVE1, '0, '0, '0, 1'b1);
    add_step("save1 read",  ACT_CHECK_MODEL, CSR_SAVE1, '0, '0, '0, 1'b0);
    add_step("save2 merge", ACT_WRITE,       CSR_SAVE2, '0, '0, '0, 1'b1);
    add_step("save2 read",  ACT_CHECK_MODEL, CSR_SAVE2, '0, '0, '0, 1'b0);
    add_step("save3 merge", ACT_WRITE,       CSR_SAVE3, '0, '0, '0, 1'b1);
    add_step("save3 read",  ACT_CHECK_MODEL, CSR_SAVE3, '0, '0, '0, 1'b0);
    add_step("ecfg merge",  ACT_WRITE,       CSR_ECFG,  '0, '0, '0, 1'b1);
    add_step("ecfg read",   ACT_CHECK_MODEL, CSR_ECFG,  '0, '0, '0, 1'b0);
    add_step("eentry fill", ACT_WRITE,       CSR_EENTRY, 32'hFFFF_FFFF, 32'h1C00_803F, '0, 1'b0);
    add_step("eentry low",  ACT_CHECK,       CSR_EENTRY, '0, '0, 32'h1C00_8000, 1'b0);
    add_step("eentry merge", ACT_WRITE,      CSR_EENTRY, '0, '0, '0, 1'b1);
    add_step("eentry read", ACT_CHECK_MODEL, CSR_EENTRY, '0, '0, '0, 1'b0);
    // commit and return
    add_step("crmd plv3 ie", ACT_WRITE,      CSR_CRMD,  32'h0000_0007, 32'h0000_0007, '0, 1'b0);
    add_step("crmd before", ACT_CHECK,       CSR_CRMD,  '0, '0, 32'h0000_000F, 1'b0);
    add_step("commit ale",  ACT_COMMIT, csr_num_t'(ECODE_ALE), 32'h1C00_0140, 32'h0000_2003,
             '0, 1'b0);
    add_step("era read",    ACT_CHECK_MODEL, CSR_ERA,   '0, '0, '0, 1'b0);
    add_step("badv read",   ACT_CHECK_MODEL, CSR_BADV,  '0, '0, '0, 1'b0);
    add_step("estat code",  ACT_CHECK_MODEL, CSR_ESTAT, '0, '0, '0, 1'b0);
    add_step("prmd saved",  ACT_CHECK_MODEL, CSR_PRMD,  '0, '0, '0, 1'b0);
    add_step("crmd in exc", ACT_CHECK,       CSR_CRMD,  '0, '0, 32'h0000_0008, 1'b0);
    add_step("ports in exc", ACT_CHECK_PORTS, CSR_CRMD, '0, '0, '0, 1'b0);
    add_step("return",      ACT_RETURN,      CSR_CRMD,  '0, '0, '0, 1'b0);
    add_step("crmd after",  ACT_CHECK,       CSR_CRMD,  '0, '0, 32'h0000_000F, 1'b0);
    add_step("ports after", ACT_CHECK_PORTS, CSR_CRMD,  '0, '0, '0, 1'b0);
    // timer interrupt, one-shot with initial value 0x40
    add_step("ecfg timer",  ACT_WRITE,       CSR_ECFG,  32'h0000_1FFF, 32'h0000_0800, '0, 1'b0);
    add_step("no int yet",  ACT_CHECK_INT,   CSR_CRMD,  '0, '0, '0, 1'b0);
    add_step("tcfg start",  ACT_WRITE,       CSR_TCFG,  32'hFFFF_FFFF, 32'h0000_0041, '0, 1'b0);
    add_step("timer wait",  ACT_WAIT_TIMER,  CSR_CRMD,  '0, '0, '0, 1'b0);
    add_step("tval zero",   ACT_CHECK,       CSR_TVAL,  '0, '0, '0, 1'b0);
    add_step("tcfg stopped", ACT_CHECK_MODEL, CSR_TCFG, '0, '0, '0, 1'b0);
    add_step("estat timer", ACT_CHECK_MODEL, CSR_ESTAT, '0, '0, '0, 1'b0);
    add_step("ticlr",       ACT_WRITE,       CSR_TICLR, 32'h0000_0001, 32'h0000_0001, '0, 1'b0);
    add_step("int cleared", ACT_CHECK_INT,   CSR_CRMD,  '0, '0, '0, 1'b0);
    // hardware line 0
    add_step("ecfg hw0",    ACT_WRITE,       CSR_ECFG,  32'h0000_0004, 32'h0000_0004, '0, 1'b0);
    add_step("hw0 raise",   ACT_HWINT,       CSR_CRMD,  '0, 32'h0000_0001, 32'h0000_0001, 1'b0);
    add_step("estat hw0",   ACT_CHECK_MODEL, CSR_ESTAT, '0, '0, '0, 1'b0);
    add_step("hw0 drop",    ACT_HWINT,       CSR_CRMD,  '0, '0, '0, 1'b0);
    // stable counter
    add_step("count gap",   ACT_COUNT,       CSR_CRMD,  '0, 32'd37, '0, 1'b0);
endtask

/* tests/csr_tb.sv */
`timescale 1ns/1ps

module csr_tb;
    import la_csr_pkg::*;
    import la_excp_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic      clk;
    logic      reset;
    csr_num_t  csr_num;
    logic      csr_we;
    word_t     csr_wmask;
    word_t     csr_wvalue;
    logic      wb_ex;
    ecode_t    wb_ecode;
    esubcode_t wb_esubcode;
    word_t     wb_pc;
    word_t     wb_vaddr;
    logic      ertn;
    hw_int_t   hw_int;
    word_t     csr_rvalue;
    word_t     ex_entry;
    word_t     ertn_entry;
    word_t     tid;
    logic      has_int;
    plv_t      crmd_plv;
    count_t    count;

    // expected register contents
    word_t     m_crmd;
    word_t     m_prmd;
    word_t     m_ecfg;
    word_t     m_era;
    word_t     m_badv;
    word_t     m_eentry;
    word_t     m_tid;
    word_t     m_tcfg;
    word_t     m_save [4];
    logic [1:0] m_swi;
    ecode_t    m_ecode;
    esubcode_t m_esubcode;
    hw_int_t   m_hw;
    logic      m_tpend;

    int        errors;
    word_t     lcg_state;

    `include "csr_tb_cases.svh"

    csr_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .csr_num_i     (csr_num),
        .csr_we_i      (csr_we),
        .csr_wmask_i   (csr_wmask),
        .csr_wvalue_i  (csr_wvalue),
        .wb_ex_i       (wb_ex),
        .wb_ecode_i    (wb_ecode),
        .wb_esubcode_i (wb_esubcode),
        .wb_pc_i       (wb_pc),
        .wb_vaddr_i    (wb_vaddr),
        .ertn_i        (ertn),
        .hw_int_i      (hw_int),
        .csr_rvalue_o  (csr_rvalue),
        .ex_entry_o    (ex_entry),
        .ertn_entry_o  (ertn_entry),
        .tid_o         (tid),
        .has_int_o     (has_int),
        .crmd_plv_o    (crmd_plv),
        .count_o       (count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void model_reset();
        m_crmd = '0;
        m_crmd[CRMD_DA_BIT] = 1'b1;
        m_prmd = '0;
        m_ecfg = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = '0;
        m_tid = RESET_TID;
        m_tcfg = '0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
        m_swi = '0;
        m_ecode = '0;
        m_esubcode = '0;
        m_hw = '0;
        m_tpend = 1'b0;
    endfunction

    function automatic word_t model_read(csr_num_t num);
        word_t pend;
        pend = '0;
        pend[1:0] = m_swi;
        pend[9:2] = m_hw;
        pend[TIMER_INT_BIT] = m_tpend;
        case (num)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return pend | (word_t'(m_ecode) << ESTAT_ECODE_LSB)
                               | (word_t'(m_esubcode) << ESTAT_ESUBCODE_LSB);
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            CSR_TID:    return m_tid;
            CSR_TCFG:   return m_tcfg;
            default:    return '0;
        endcase
    endfunction

    function automatic void model_write(csr_num_t num, word_t mask, word_t value);
        word_t merged;
        merged = (value & mask) | (model_read(num) & ~mask);
        case (num)
            CSR_CRMD:   m_crmd = merged & 32'h0000_000F;
            CSR_PRMD:   m_prmd = merged & 32'h0000_0007;
            CSR_ECFG:   m_ecfg = merged & 32'h0000_1FFF;
            CSR_ESTAT:  m_swi = merged[1:0];
            CSR_ERA:    m_era = merged;
            CSR_BADV:   m_badv = merged;
            CSR_EENTRY: m_eentry = merged & ~32'h0000_003F;
            CSR_SAVE0:  m_save[0] = merged;
            CSR_SAVE1:  m_save[1] = merged;
            CSR_SAVE2:  m_save[2] = merged;
            CSR_SAVE3:  m_save[3] = merged;
            CSR_TID:    m_tid = merged;
            CSR_TCFG:   m_tcfg = merged;
            CSR_TICLR: begin
                if (mask[TICLR_CLR_BIT] && value[TICLR_CLR_BIT]) begin
                    m_tpend = 1'b0;
                end
            end
            default: ;
        endcase
    endfunction

    // old level and enable move to prmd while da stays
    function automatic void model_commit(ecode_t ecode, word_t pc, word_t vaddr);
        m_prmd = m_crmd & 32'h0000_0007;
        m_crmd = m_crmd & ~32'h0000_0007;
        m_era = pc;
        m_ecode = ecode;
        m_esubcode = ESUBCODE_NONE;
        if (ecode == ECODE_ADEF) begin
            m_badv = pc;
        end else if (ecode == ECODE_ALE) begin
            m_badv = vaddr;
        end
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("sim failed");
            $display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_step(step_t st);
        word_t  mask;
        word_t  value;
        count_t start;
        int     waited;
        @(negedge clk);
        csr_we = 1'b0;
        wb_ex = 1'b0;
        ertn = 1'b0;
        mask = st.mask;
        value = st.value;
        if (st.rnd) begin
            mask = lcg_next();
            value = lcg_next();
        end
        case (st.act)
            ACT_WRITE: begin
                csr_num = st.num;
                csr_wmask = mask;
                csr_wvalue = value;
                csr_we = 1'b1;
                model_write(st.num, mask, value);
            end
            ACT_CHECK: begin
                csr_num = st.num;
                #1;
                check_word(st.name, st.expected, csr_rvalue);
            end
            ACT_CHECK_MODEL: begin
                csr_num = st.num;
                #1;
                check_word(st.name, model_read(st.num), csr_rvalue);
            end
            ACT_COMMIT: begin
                wb_ecode = ecode_t'(st.num);
                wb_esubcode = ESUBCODE_NONE;
                wb_pc = mask;
                wb_vaddr = value;
                wb_ex = 1'b1;
                model_commit(ecode_t'(st.num), mask, value);
            end
            ACT_RETURN: begin
                ertn = 1'b1;
                m_crmd = (m_crmd & ~32'h0000_0007) | (m_prmd & 32'h0000_0007);
            end
            ACT_HWINT: begin
                hw_int = hw_int_t'(value);
                m_hw = hw_int_t'(value);
                #1;
                check_word(st.name, st.expected, {31'b0, has_int});
            end
            ACT_CHECK_INT: begin
                #1;
                check_word(st.name, st.expected, {31'b0, has_int});
            end
            ACT_CHECK_PORTS: begin
                #1;
                check_word({st.name, " ex_entry"}, m_eentry, ex_entry);
                check_word({st.name, " ertn_entry"}, m_era, ertn_entry);
                check_word({st.name, " plv"}, {30'b0, m_crmd[1:0]}, {30'b0, crmd_plv});
                check_word({st.name, " tid"}, m_tid, tid);
            end
            ACT_WAIT_TIMER: begin
                waited = 0;
                while (!has_int && waited < WAIT_LIMIT) begin
                    @(negedge clk);
                    waited++;
                end
                assert (has_int) else begin
                    errors++;
                    $display("sim failed");
                    $display("timeout in %s: has_int_o did not rise after %0d cycles",
                             st.name, WAIT_LIMIT);
                    $fatal(1, "timer wait timed out");
                end
                // one-shot timer drops its enable when it fires
                m_tpend = 1'b1;
                if (!m_tcfg[TCFG_PERIODIC_BIT]) begin
                    m_tcfg[TCFG_EN_BIT] = 1'b0;
                end
            end
            ACT_COUNT: begin
                start = count;
                repeat (value) @(negedge clk);
                check_word(st.name, value, word_t'(count - start));
            end
            default: ;
        endcase
    endtask

    initial begin
        errors = 0;
        lcg_state = 32'd79250;
        reset = 1'b1;
        csr_num = '0;
        csr_we = 1'b0;
        csr_wmask = '0;
        csr_wvalue = '0;
        wb_ex = 1'b0;
        wb_ecode = '0;
        wb_esubcode = '0;
        wb_pc = '0;
        wb_vaddr = '0;
        ertn = 1'b0;
        hw_int = '0;
        model_reset();
        load_cases();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            apply_step(steps[i]);
        end

        @(negedge clk);
        csr_we = 1'b0;
        wb_ex = 1'b0;
        ertn = 1'b0;
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* hdl/csr_top.sv */
`timescale 1ns/1ps

module csr_top (
    input  logic                    clk,
    input  logic                    reset,
    input  la_csr_pkg::csr_num_t    csr_num_i,
    input  logic                    csr_we_i,
    input  la_csr_pkg::word_t       csr_wmask_i,
    input  la_csr_pkg::word_t       csr_wvalue_i,
    input  logic                    wb_ex_i,
    input  la_excp_pkg::ecode_t     wb_ecode_i,
    input  la_excp_pkg::esubcode_t  wb_esubcode_i,
    input  la_csr_pkg::word_t       wb_pc_i,
    input  la_csr_pkg::word_t       wb_vaddr_i,
    input  logic                    ertn_i,
    input  la_excp_pkg::hw_int_t    hw_int_i,
    output la_csr_pkg::word_t       csr_rvalue_o,
    output la_csr_pkg::word_t       ex_entry_o,
    output la_csr_pkg::word_t       ertn_entry_o,
    output la_csr_pkg::word_t       tid_o,
    output logic                    has_int_o,
    output la_csr_pkg::plv_t        crmd_plv_o,
    output la_csr_pkg::count_t      count_o
);
    import la_csr_pkg::*;

    word_t tcfg;
    word_t tval;
    logic  timer_int;

    // timer, counter and timer pending
    csr_timer timer_i (
        .clk          (clk),
        .reset        (reset),
        .csr_num_i    (csr_num_i),
        .csr_we_i     (csr_we_i),
        .csr_wmask_i  (csr_wmask_i),
        .csr_wvalue_i (csr_wvalue_i),
        .tcfg_o       (tcfg),
        .tval_o       (tval),
        .timer_int_o  (timer_int),
        .count_o      (count_o)
    );

    csr_regs regs_i (
        .clk           (clk),
        .reset         (reset),
        .csr_num_i     (csr_num_i),
        .csr_we_i      (csr_we_i),
        .csr_wmask_i   (csr_wmask_i),
        .csr_wvalue_i  (csr_wvalue_i),
        .wb_ex_i       (wb_ex_i),
        .wb_ecode_i    (wb_ecode_i),
        .wb_esubcode_i (wb_esubcode_i),
        .wb_pc_i       (wb_pc_i),
        .wb_vaddr_i    (wb_vaddr_i),
        .ertn_i        (ertn_i),
        .hw_int_i      (hw_int_i),
        .timer_int_i   (timer_int),
        .tcfg_i        (tcfg),
        .tval_i        (tval),
        .csr_rvalue_o  (csr_rvalue_o),
        .ex_entry_o    (ex_entry_o),
        .ertn_entry_o  (ertn_entry_o),
        .tid_o         (tid_o),
        .has_int_o     (has_int_o),
        .crmd_plv_o    (crmd_plv_o)
    );

endmodule

/* hdl/csr_regs.sv */
`timescale 1ns/1ps

module csr_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  la_csr_pkg::csr_num_t    csr_num_i,
    input  logic                    csr_we_i,
    input  la_csr_pkg::word_t       csr_wmask_i,
    input  la_csr_pkg::word_t       csr_wvalue_i,
    input  logic                    wb_ex_i,
    input  la_excp_pkg::ecode_t     wb_ecode_i,
    input  la_excp_pkg::esubcode_t  wb_esubcode_i,
    input  la_csr_pkg::word_t       wb_pc_i,
    input  la_csr_pkg::word_t       wb_vaddr_i,
    input  logic                    ertn_i,
    input  la_excp_pkg::hw_int_t    hw_int_i,
    input  logic                    timer_int_i,
    input  la_csr_pkg::word_t       tcfg_i,
    input  la_csr_pkg::word_t       tval_i,
    output la_csr_pkg::word_t       csr_rvalue_o,
    output la_csr_pkg::word_t       ex_entry_o,
    output la_csr_pkg::word_t       ertn_entry_o,
    output la_csr_pkg::word_t       tid_o,
    output logic                    has_int_o,
    output la_csr_pkg::plv_t        crmd_plv_o
);
    import la_csr_pkg::*;
    import la_excp_pkg::*;

    // current and saved mode
    plv_t       crmd_plv_q;
    logic       crmd_ie_q;
    logic       crmd_da_q;
    plv_t       prmd_pplv_q;
    logic       prmd_pie_q;

    int_vec_t   ecfg_lie_q;
    logic [1:0] estat_swi_q;
    ecode_t     estat_ecode_q;
    esubcode_t  estat_esubcode_q;
    word_t      era_q;
    word_t      badv_q;
    logic [31:EENTRY_ALIGN_BITS] eentry_q;
    word_t      save_q [4];
    word_t      tid_q;

    int_vec_t   int_pending;
    word_t      crmd_rd;
    word_t      prmd_rd;
    word_t      estat_rd;
    word_t      rd_value;
    word_t      wr_merged;

    // pending lines, perf and ipi stay low
    always_comb begin
        int_pending = '0;
        int_pending[1:0] = estat_swi_q;
        int_pending[9:2] = hw_int_i;
        int_pending[TIMER_INT_BIT] = timer_int_i;
    end

    always_comb begin
        crmd_rd = '0;
        crmd_rd[1:0] = crmd_plv_q;
        crmd_rd[CRMD_IE_BIT] = crmd_ie_q;
        crmd_rd[CRMD_DA_BIT] = crmd_da_q;
    end

    // prmd keeps pie at the same position as crmd.ie
    always_comb begin
        prmd_rd = '0;
        prmd_rd[1:0] = prmd_pplv_q;
        prmd_rd[CRMD_IE_BIT] = prmd_pie_q;
    end

    always_comb begin
        estat_rd = '0;
        estat_rd[$bits(int_vec_t)-1:0] = int_pending;
        estat_rd[ESTAT_ECODE_LSB +: $bits(ecode_t)] = estat_ecode_q;
        estat_rd[ESTAT_ESUBCODE_LSB +: $bits(esubcode_t)] = estat_esubcode_q;
    end

    always_comb begin
        case (csr_num_i)
            CSR_CRMD:   rd_value = crmd_rd;
            CSR_PRMD:   rd_value = prmd_rd;
            CSR_ECFG:   rd_value = word_t'(ecfg_lie_q);
            CSR_ESTAT:  rd_value = estat_rd;
            CSR_ERA:    rd_value = era_q;
            CSR_BADV:   rd_value = badv_q;
            CSR_EENTRY: rd_value = {eentry_q, {EENTRY_ALIGN_BITS{1'b0}}};
            CSR_SAVE0:  rd_value = save_q[0];
            CSR_SAVE1:  rd_value = save_q[1];
            CSR_SAVE2:  rd_value = save_q[2];
            CSR_SAVE3:  rd_value = save_q[3];
            CSR_TID:    rd_value = tid_q;
            CSR_TCFG:   rd_value = tcfg_i;
            CSR_TVAL:   rd_value = tval_i;
            default:    rd_value = '0;
        endcase
    end

    // read and write share the address, so merge against the read value
    assign wr_merged = (csr_wvalue_i & csr_wmask_i) | (rd_value & ~csr_wmask_i);

    // later assignments win: commit over return over write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv_q       <= '0;
            crmd_ie_q        <= 1'b0;
            crmd_da_q        <= 1'b1;
            prmd_pplv_q      <= '0;
            prmd_pie_q       <= 1'b0;
            ecfg_lie_q       <= '0;
            estat_swi_q      <= '0;
            estat_ecode_q    <= '0;
            estat_esubcode_q <= '0;
            era_q            <= '0;
            badv_q           <= '0;
            eentry_q         <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
            tid_q            <= RESET_TID;
        end else begin
            if (csr_we_i) begin
                case (csr_num_i)
                    CSR_CRMD: begin
                        crmd_plv_q <= wr_merged[1:0];
                        crmd_ie_q  <= wr_merged[CRMD_IE_BIT];
                        crmd_da_q  <= wr_merged[CRMD_DA_BIT];
                    end
                    CSR_PRMD: begin
                        prmd_pplv_q <= wr_merged[1:0];
                        prmd_pie_q  <= wr_merged[CRMD_IE_BIT];
                    end
                    CSR_ECFG:   ecfg_lie_q  <= wr_merged[$bits(int_vec_t)-1:0];
                    // only the software lines are writable
                    CSR_ESTAT:  estat_swi_q <= wr_merged[1:0];
                    CSR_ERA:    era_q       <= wr_merged;
                    CSR_BADV:   badv_q      <= wr_merged;
                    CSR_EENTRY: eentry_q    <= wr_merged[31:EENTRY_ALIGN_BITS];
                    CSR_SAVE0:  save_q[0]   <= wr_merged;
                    CSR_SAVE1:  save_q[1]   <= wr_merged;
                    CSR_SAVE2:  save_q[2]   <= wr_merged;
                    CSR_SAVE3:  save_q[3]   <= wr_merged;
                    CSR_TID:    tid_q       <= wr_merged;
                    default: ;
                endcase
            end

            if (ertn_i) begin
                crmd_plv_q <= prmd_pplv_q;
                crmd_ie_q  <= prmd_pie_q;
            end

            if (wb_ex_i) begin
                prmd_pplv_q      <= crmd_plv_q;
                prmd_pie_q       <= crmd_ie_q;
                crmd_plv_q       <= '0;
                crmd_ie_q        <= 1'b0;
                era_q            <= wb_pc_i;
                estat_ecode_q    <= wb_ecode_i;
                estat_esubcode_q <= wb_esubcode_i;
                // fetch faults report the pc, alignment faults the data address
                if (wb_ecode_i == ECODE_ADEF) begin
                    badv_q <= wb_pc_i;
                end else if (wb_ecode_i == ECODE_ALE) begin
                    badv_q <= wb_vaddr_i;
                end
            end
        end
    end

    assign csr_rvalue_o = rd_value;
    assign ex_entry_o   = {eentry_q, {EENTRY_ALIGN_BITS{1'b0}}};
    assign ertn_entry_o = era_q;
    assign tid_o        = tid_q;
    assign crmd_plv_o   = crmd_plv_q;
    assign has_int_o    = (|(int_pending & ecfg_lie_q)) && crmd_ie_q;

    // writeback never commits and returns in one cycle
    assert property (@(posedge clk) disable iff (reset)
        !(wb_ex_i && ertn_i))
        else $error("commit and return in the same cycle");

    assert property (@(posedge clk) disable iff (reset)
        wb_ex_i |=> !crmd_ie_q)
        else $error("interrupts still enabled after a commit");

endmodule

/* hdl/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  la_csr_pkg::csr_num_t csr_num_i,
    input  logic                 csr_we_i,
    input  la_csr_pkg::word_t    csr_wmask_i,
    input  la_csr_pkg::word_t    csr_wvalue_i,
    output la_csr_pkg::word_t    tcfg_o,
    output la_csr_pkg::word_t    tval_o,
    output logic                 timer_int_o,
    output la_csr_pkg::count_t   count_o
);
    import la_csr_pkg::*;

    count_t count_q;
    word_t  tcfg_q;
    word_t  tval_q;
    logic   timer_int_q;

    word_t  tcfg_wdata;
    word_t  tcfg_init;
    word_t  wr_init;
    logic   tcfg_we;
    logic   ticlr_we;
    logic   timer_en;
    logic   expire;

    assign tcfg_we  = csr_we_i && (csr_num_i == CSR_TCFG);
    assign ticlr_we = csr_we_i && (csr_num_i == CSR_TICLR)
                      && csr_wmask_i[TICLR_CLR_BIT] && csr_wvalue_i[TICLR_CLR_BIT];

    assign tcfg_wdata = (csr_wvalue_i & csr_wmask_i) | (tcfg_q & ~csr_wmask_i);

    // initial value is tcfg with the control bits cleared
    assign tcfg_init = {tcfg_q[31:2], 2'b00};
    assign wr_init   = {tcfg_wdata[31:2], 2'b00};

    assign timer_en = tcfg_q[TCFG_EN_BIT];
    assign expire   = timer_en && (tval_q == '0);

    // free-running stable counter
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_q <= '0;
        end else if (tcfg_we) begin
            tcfg_q <= tcfg_wdata;
        end else if (expire && !tcfg_q[TCFG_PERIODIC_BIT]) begin
            // one-shot timer stops itself
            tcfg_q[TCFG_EN_BIT] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval_q <= '0;
        end else if (tcfg_we && tcfg_wdata[TCFG_EN_BIT]) begin
            tval_q <= wr_init;
        end else if (expire && tcfg_q[TCFG_PERIODIC_BIT]) begin
            tval_q <= tcfg_init;
        end else if (timer_en && (tval_q != '0)) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // clear wins over a set at the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int_q <= 1'b0;
        end else if (ticlr_we) begin
            timer_int_q <= 1'b0;
        end else if (expire) begin
            timer_int_q <= 1'b1;
        end
    end

    assign tcfg_o      = tcfg_q;
    assign tval_o      = tval_q;
    assign timer_int_o = timer_int_q;
    assign count_o     = count_q;

    // countdown stays within the loaded period while running
    assert property (@(posedge clk) disable iff (reset)
        timer_en |-> (tval_q <= tcfg_init))
        else $error("tval above the loaded initial value");

    assert property (@(posedge clk) disable iff (reset)
        $rose(timer_int_q) |-> $past(expire))
        else $error("timer pending set without an expiry");

endmodule

/* hdl/la_excp_pkg.sv */
package la_excp_pkg;

    // cause fields as carried down the pipe
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // 1:0 software, 9:2 hardware, 10 perf, 11 timer, 12 ipi
    typedef logic [12:0] int_vec_t;

    // external interrupt lines
    typedef logic [7:0] hw_int_t;

    // cause codes
    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_ADEF = 6'h08;
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0B;
    localparam ecode_t ECODE_BRK  = 6'h0C;
    localparam ecode_t ECODE_INE  = 6'h0D;
    localparam ecode_t ECODE_IPE  = 6'h0E;

    // all causes here use subcode zero
    localparam esubcode_t ESUBCODE_NONE = 9'h000;

endpackage

/* hdl/la_csr_pkg.sv */
package la_csr_pkg;

    // register-width types
    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [1:0]  plv_t;
    typedef logic [63:0] count_t;

    // register numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00C;

    // scratch registers for the handler
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;

    // timer block
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // crmd fields, plv sits in bits 1:0
    localparam int CRMD_IE_BIT = 2;
    localparam int CRMD_DA_BIT = 3;

    // tcfg fields, the initial value lives above bit 1
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;

    // timer line in the pending vector
    localparam int TIMER_INT_BIT = 11;

    localparam int TICLR_CLR_BIT = 0;

    // estat cause fields
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;

    // entry address is 64-byte aligned
    localparam int EENTRY_ALIGN_BITS = 6;

    // core identity seen through tid
    localparam word_t RESET_TID = 32'h0000_0001;

endpackage
